//--- list.f
+incdir+.
fpu_cfg_pkg.sv
fpu_op_pkg.sv
fpu_op_decode.sv
fpu_issue_fsm.sv
fpu_hold_buffer.sv
fpu_noncomp_pipe.sv
fpu_occupancy_counter.sv
fpu_wrap.sv
tb_fpu_wrap.sv

//--- run.sh
#!/bin/sh
# Build and run the FP32 unit testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu_wrap -f list.f \
    && ./obj_dir/Vtb_fpu_wrap > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- tb_fpu_model.svh
// Reference model of the FP32 unit, included by the testbench to predict result and flags
`ifndef TB_FPU_MODEL_SVH
`define TB_FPU_MODEL_SVH

// Unsigned order of keys follows the real order, -0 below +0
function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
endfunction

function automatic bit is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
endfunction

function automatic bit is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];  // Quiet bit clear
endfunction

// RISC-V FCLASS bit positions
function automatic logic [9:0] expected_class(input logic [31:0] x);
    logic [9:0] mask;
    mask = 10'd0;
    if (is_nan(x))                 mask = x[22] ? 10'h200 : 10'h100;
    else if (x[30:23] == 8'hff)    mask = x[31] ? 10'h001 : 10'h080;  // Infinity
    else if (x[30:0] == 31'd0)     mask = x[31] ? 10'h008 : 10'h010;  // Zero
    else if (x[30:23] == 8'h00)    mask = x[31] ? 10'h004 : 10'h020;  // Subnormal
    else                           mask = x[31] ? 10'h002 : 10'h040;  // Normal
    return mask;
endfunction

function automatic logic [31:0] expected_result(input fu_op_e op, input logic [2:0] rm,
                                                input logic [31:0] a, input logic [31:0] b);
    logic        zeros;
    logic        eq;
    logic        lt;
    logic [31:0] res;
    zeros = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
    eq    = !is_nan(a) && !is_nan(b) && ((a == b) || zeros);
    lt    = !is_nan(a) && !is_nan(b) && !zeros && (order_key(a) < order_key(b));
    res   = a;                                    // Moves and rm 3 pass a through
    case (op)
        FSGNJ: begin
            if (rm[1:0] == 2'd0)      res = {b[31], a[30:0]};
            else if (rm[1:0] == 2'd1) res = {~b[31], a[30:0]};
            else if (rm[1:0] == 2'd2) res = {a[31] ^ b[31], a[30:0]};
        end
        FMIN_MAX: begin
            if (is_nan(a) && is_nan(b)) res = CANON_NAN;
            else if (is_nan(a))         res = b;
            else if (is_nan(b))         res = a;
            else if (rm[1:0] == 2'd1)   res = (order_key(a) < order_key(b)) ? b : a;
            else                        res = (order_key(a) < order_key(b)) ? a : b;
        end
        FCMP: begin
            if (rm[1:0] == 2'd0)      res = {31'd0, lt || eq};
            else if (rm[1:0] == 2'd1) res = {31'd0, lt};
            else if (rm[1:0] == 2'd2) res = {31'd0, eq};
            else                      res = 32'd0;
        end
        FCLASS:  res = {22'd0, expected_class(a)};
        default: ;
    endcase
    return res;
endfunction

// Only NV can rise, from NaN inputs
function automatic status_t expected_flags(input fu_op_e op, input logic [2:0] rm,
                                           input logic [31:0] a, input logic [31:0] b);
    logic nv;
    nv = 1'b0;
    if (op == FMIN_MAX)                       nv = is_snan(a) || is_snan(b);
    else if (op == FCMP && rm[1:0] == 2'd2)   nv = is_snan(a) || is_snan(b);
    else if (op == FCMP && rm[1:0] != 2'd3)   nv = is_nan(a) || is_nan(b);
    return {nv, 4'b0000};
endfunction

`endif

//--- tb_fpu_wrap.sv
// Self-checking top of the FP32 unit simulation that drives random commands, back-pressure and flush
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_wrap;
    import fpu_cfg_pkg::*;
    import fpu_op_pkg::*;

    localparam int unsigned NUM_STAGES = 2;
    localparam int unsigned NUM_CMDS   = 600;  // Commands over all phases
    localparam int unsigned CLK_PERIOD = 8;

    logic     clk_i;
    logic     rst_i;
    logic     flush_i;
    logic     fpu_valid_i;
    logic     fpu_ready_o;
    fu_op_e   fu_op_i;
    sub_op_t  rm_i;
    operand_t operand_a_i;
    operand_t operand_b_i;
    tag_t     trans_id_i;
    logic     fpu_valid_o;
    logic     out_ready_i;
    operand_t result_o;
    status_t  fflags_o;
    tag_t     fpu_trans_id_o;
    logic     busy_o;

    // Scoreboard with one entry per accepted command
    operand_t exp_res_q[$];
    status_t  exp_flags_q[$];
    tag_t     exp_tag_q[$];
    int       entry_q[$];     // Cycle of pipeline entry or -1 when held first

    integer   seed;
    int       cyc, errors, checks, accepted, in_pipe;
    bit       stalled, timed_phase, idle_check, prev_blocked;
    bit [NUM_STAGES-1:0] occ_q;  // Expected valid bit per stage, last stage on top
    operand_t prev_res;
    status_t  prev_flags;
    tag_t     prev_tag;

    `include "tb_fpu_model.svh"

    fpu_wrap #(.NUM_STAGES(NUM_STAGES)) u_dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Biased toward zeros, NaNs, infinities and subnormals
    function automatic operand_t random_operand();
        logic [31:0] r;
        logic [31:0] m;
        operand_t    x;
        r = $random(seed);
        m = $random(seed);
        case (r[2:0])
            3'd0:    x = {r[31], 31'd0};
            3'd1:    x = {r[31], 8'hff, 1'b1, m[21:0]};        // Quiet NaN
            3'd2:    x = {r[31], 8'hff, 1'b0, m[21:1], 1'b1};  // Signaling NaN
            3'd3:    x = {r[31], 8'hff, 23'd0};
            3'd4:    x = {r[31], 8'h00, m[22:1], 1'b1};
            default: x = m;
        endcase
        return x;
    endfunction

    // ----------------------------------------
    // Observation at mid cycle
    // ----------------------------------------
    task automatic observe_cycle();
        int entry;
        bit ready_exp;
        bit advance_exp;
        bit enter;
        advance_exp = out_ready_i || !occ_q[NUM_STAGES-1];  // Sink takes it or last stage empty
        enter       = advance_exp && (fpu_valid_i || stalled);
        check_value("fpu_valid_o", fpu_valid_o, occ_q[NUM_STAGES-1]);
        check_value("busy_o", busy_o, in_pipe != 0);
        ready_exp = (!fpu_valid_i && !stalled) || advance_exp;  // Full pipe blocks
        check_value("fpu_ready_o", fpu_ready_o, ready_exp);
        if (prev_blocked) begin  // Frozen under back-pressure
            check_value("stalled fpu_valid_o", fpu_valid_o, 1);
            check_value("stalled result_o", result_o, prev_res);
            check_value("stalled fflags_o", fflags_o, prev_flags);
            check_value("stalled fpu_trans_id_o", fpu_trans_id_o, prev_tag);
        end
        if (idle_check) begin
            check_value("fpu_valid_o after flush", fpu_valid_o, 0);
            check_value("busy_o after flush", busy_o, 0);
        end
        if (fpu_valid_o && out_ready_i) begin
            if (exp_res_q.size() == 0) begin
                errors++;
                $display("Error at %0t: result with tag %0d arrived with no command pending",
                         $time, fpu_trans_id_o);
            end else begin
                check_value("result_o", result_o, exp_res_q.pop_front());
                check_value("fflags_o", fflags_o, exp_flags_q.pop_front());
                check_value("fpu_trans_id_o", fpu_trans_id_o, exp_tag_q.pop_front());
                entry = entry_q.pop_front();
                if (timed_phase && entry >= 0) check_value("latency", cyc - entry, NUM_STAGES);
                in_pipe--;
            end
        end
        if (fpu_valid_i && !stalled) begin  // READY takes every command whether live or held
            exp_res_q.push_back(expected_result(fu_op_i, rm_i, operand_a_i, operand_b_i));
            exp_flags_q.push_back(expected_flags(fu_op_i, rm_i, operand_a_i, operand_b_i));
            exp_tag_q.push_back(trans_id_i);
            accepted++;
            if (fpu_ready_o) begin
                entry_q.push_back(cyc);
                in_pipe++;
            end else begin
                entry_q.push_back(-1);
                stalled = 1'b1;              // Held in the buffer
            end
        end else if (stalled && fpu_ready_o) begin
            stalled = 1'b0;                  // Held command enters the pipe
            in_pipe++;
        end
        prev_blocked = fpu_valid_o && !out_ready_i && !flush_i;
        prev_res     = result_o;
        prev_flags   = fflags_o;
        prev_tag     = fpu_trans_id_o;
        if (flush_i) begin                   // Everything in flight is dropped
            exp_res_q.delete();
            exp_flags_q.delete();
            exp_tag_q.delete();
            entry_q.delete();
            stalled = 1'b0;
            in_pipe = 0;
            occ_q   = '0;
        end else if (advance_exp) begin
            occ_q = (occ_q << 1) | enter;    // Stages move together
        end
        cyc++;
    endtask

    task automatic drive_inputs(input bit issue_en, input bit ready_always);
        logic [31:0] r;
        r = $random(seed);
        fpu_valid_i = issue_en && !stalled && (r[1:0] != 2'b00);
        fu_op_i     = fu_op_e'(r[6:4] % 3'd6);
        rm_i        = r[10:8];
        operand_a_i = random_operand();
        operand_b_i = (r[13:11] == 3'd0) ? operand_a_i : random_operand();  // Equal pairs
        trans_id_i  = tag_t'(accepted);
        out_ready_i = ready_always || (r[17:16] != 2'b00);
    endtask

    task automatic step(input bit issue_en, input bit ready_always);
        @(negedge clk_i);
        observe_cycle();
        @(posedge clk_i);
        #1;
        drive_inputs(issue_en, ready_always);
    endtask

    // Flush with issue and sink idle and then watch for silence
    task automatic flush_episode();
        fpu_valid_i = 1'b0;
        out_ready_i = 1'b0;
        flush_i     = 1'b1;
        @(negedge clk_i);
        observe_cycle();
        @(posedge clk_i);
        #1;
        flush_i    = 1'b0;
        idle_check = 1'b1;
        repeat (6) step(0, 0);
        idle_check = 1'b0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed        = 32'hc275_8474;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        flush_i     = 1'b0;
        fpu_valid_i = 1'b0;
        fu_op_i     = FSGNJ;
        rm_i        = '0;
        operand_a_i = '0;
        operand_b_i = '0;
        trans_id_i  = '0;
        out_ready_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_value("fpu_valid_o after reset", fpu_valid_o, 0);
        timed_phase = 1'b1;                   // Sink always ready for the exact latency check
        while (accepted < NUM_CMDS / 4) step(1, 1);
        while (exp_res_q.size() != 0) step(0, 1);
        timed_phase = 1'b0;
        while (accepted < NUM_CMDS / 2) step(1, 0);
        repeat (3) begin
            repeat (25) step(1, 0);
            flush_episode();
        end
        while (accepted < NUM_CMDS) step(1, 0);
        while (exp_res_q.size() != 0) step(0, 1);
        repeat (4) step(0, 1);                // Nothing extra may appear
        $display("Run done: %0d commands, %0d checks, %0d errors", accepted, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog scaled to the command count
    initial begin
        #(CLK_PERIOD * (NUM_CMDS * (NUM_STAGES + 20) + 200));
        $display("Timeout: the run did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- fpu_wrap.sv
// Top of the FP32 non-computational unit, connecting decode, issue FSM, hold buffer and pipeline
`timescale 1ns/1ps
`default_nettype none

module fpu_wrap #(
    parameter int unsigned NUM_STAGES = 2  // Legal range 1 to 4
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  flush_i,
    input  logic                  fpu_valid_i,
    output logic                  fpu_ready_o,
    input  fpu_op_pkg::fu_op_e    fu_op_i,
    input  fpu_op_pkg::sub_op_t   rm_i,
    input  fpu_cfg_pkg::operand_t operand_a_i,
    input  fpu_cfg_pkg::operand_t operand_b_i,
    input  fpu_cfg_pkg::tag_t     trans_id_i,
    output logic                  fpu_valid_o,
    input  logic                  out_ready_i,
    output fpu_cfg_pkg::operand_t result_o,
    output fpu_cfg_pkg::status_t  fflags_o,
    output fpu_cfg_pkg::tag_t     fpu_trans_id_o,
    output logic                  busy_o
);
    import fpu_cfg_pkg::*;
    import fpu_op_pkg::*;

    // Decoded live command
    unit_op_e dec_unit_op;
    logic     dec_op_mod;
    sub_op_t  dec_sub_op;

    // Command as seen by the pipeline
    unit_op_e unit_op;
    logic     op_mod;
    sub_op_t  sub_op;
    operand_t op_a, op_b;
    tag_t     tag;

    // Handshake glue
    logic unit_valid, unit_ready, hold, use_hold;
    logic in_fire, out_fire;

    assign in_fire  = unit_valid && unit_ready;
    assign out_fire = fpu_valid_o && out_ready_i;

    fpu_op_decode u_decode (
        .fu_op_i   (fu_op_i),
        .rm_i      (rm_i),
        .unit_op_o (dec_unit_op),
        .op_mod_o  (dec_op_mod),
        .sub_op_o  (dec_sub_op)
    );

    fpu_issue_fsm u_issue_fsm (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .fpu_valid_i  (fpu_valid_i),
        .unit_ready_i (unit_ready),
        .fpu_ready_o  (fpu_ready_o),
        .unit_valid_o (unit_valid),
        .hold_o       (hold),
        .use_hold_o   (use_hold)
    );

    fpu_hold_buffer u_hold_buffer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .hold_i      (hold),
        .use_hold_i  (use_hold),
        .unit_op_i   (dec_unit_op),
        .op_mod_i    (dec_op_mod),
        .sub_op_i    (dec_sub_op),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .tag_i       (trans_id_i),
        .unit_op_o   (unit_op),
        .op_mod_o    (op_mod),
        .sub_op_o    (sub_op),
        .operand_a_o (op_a),
        .operand_b_o (op_b),
        .tag_o       (tag)
    );

    fpu_noncomp_pipe #(
        .NUM_STAGES (NUM_STAGES)
    ) u_pipe (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .in_valid_i  (unit_valid),
        .in_ready_o  (unit_ready),
        .unit_op_i   (unit_op),
        .op_mod_i    (op_mod),
        .sub_op_i    (sub_op),
        .operand_a_i (op_a),
        .operand_b_i (op_b),
        .tag_i       (tag),
        .out_valid_o (fpu_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o),
        .status_o    (fflags_o),
        .tag_o       (fpu_trans_id_o)
    );

    fpu_occupancy_counter #(
        .NUM_STAGES (NUM_STAGES)
    ) u_occupancy (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .in_fire_i  (in_fire),
        .out_fire_i (out_fire),
        .busy_o     (busy_o)
    );

endmodule

`default_nettype wire

//--- fpu_occupancy_counter.sv
// Tracks operations in flight between issue and result handshakes, and drives busy
`timescale 1ns/1ps
`default_nettype none

module fpu_occupancy_counter #(
    parameter int unsigned NUM_STAGES = 2
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic flush_i,
    input  logic in_fire_i,   // Command entered stage 1
    input  logic out_fire_i,  // Result taken by the sink
    output logic busy_o
);

    localparam int unsigned CNT_W = $clog2(NUM_STAGES + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            count_q <= '0;
        end else if (in_fire_i && !out_fire_i) begin
            count_q <= count_q + 1'b1;
        end else if (out_fire_i && !in_fire_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign busy_o = count_q != '0;

    // ----------------------------------------
    // Depth guards
    // ----------------------------------------
    // A full pipeline accepts only while it also drains
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        in_fire_i |-> count_q < NUM_STAGES || out_fire_i);

    // No result without a matching command
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
        out_fire_i |-> count_q != '0);

endmodule

`default_nettype wire

//--- fpu_noncomp_pipe.sv
// FP32 sign injection, min/max, compare, classify and moves, followed by stallable stage registers
`timescale 1ns/1ps
`default_nettype none

module fpu_noncomp_pipe #(
    parameter int unsigned NUM_STAGES = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  flush_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  fpu_op_pkg::unit_op_e  unit_op_i,
    input  logic                  op_mod_i,     // Inverts compare result
    input  fpu_op_pkg::sub_op_t   sub_op_i,
    input  fpu_cfg_pkg::operand_t operand_a_i,
    input  fpu_cfg_pkg::operand_t operand_b_i,
    input  fpu_cfg_pkg::tag_t     tag_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output fpu_cfg_pkg::operand_t result_o,
    output fpu_cfg_pkg::status_t  status_o,
    output fpu_cfg_pkg::tag_t     tag_o
);
    import fpu_cfg_pkg::*;
    import fpu_op_pkg::*;

    // One-hot class of a single operand
    function automatic class_t classify(operand_t x);
        logic   exp_ones;
        logic   exp_zero;
        logic   mant_zero;
        class_t mask;
        exp_ones  = &x[30:23];
        exp_zero  = ~|x[30:23];
        mant_zero = ~|x[22:0];
        mask      = '0;
        if (exp_ones && !mant_zero)     mask[x[22] ? 9 : 8] = 1'b1;  // Quiet / signaling NaN
        else if (exp_ones)              mask[x[31] ? 0 : 7] = 1'b1;  // Infinity
        else if (exp_zero && mant_zero) mask[x[31] ? 3 : 4] = 1'b1;  // Zero
        else if (exp_zero)              mask[x[31] ? 2 : 5] = 1'b1;  // Subnormal
        else                            mask[x[31] ? 1 : 6] = 1'b1;  // Normal
        return mask;
    endfunction

    // ----------------------------------------
    // Operand properties
    // ----------------------------------------
    class_t   class_a, class_b;
    logic     a_nan, b_nan, any_nan, any_snan;
    logic     both_zero, a_lt_b, ieee_eq, ieee_lt, cmp_bit, nv;
    operand_t res_d;

    assign class_a   = classify(operand_a_i);
    assign class_b   = classify(operand_b_i);
    assign a_nan     = |class_a[9:8];
    assign b_nan     = |class_b[9:8];
    assign any_nan   = a_nan || b_nan;
    assign any_snan  = class_a[8] || class_b[8];
    assign both_zero = (|class_a[4:3]) && (|class_b[4:3]);

    // Total order on sign-magnitude, -0 below +0
    assign a_lt_b = (operand_a_i[31] != operand_b_i[31]) ? operand_a_i[31] :
                    operand_a_i[31] ? (operand_a_i[30:0] > operand_b_i[30:0]) :
                                      (operand_a_i[30:0] < operand_b_i[30:0]);

    // IEEE relations, zeros compare equal and NaN is unordered
    assign ieee_eq = !any_nan && (operand_a_i == operand_b_i || both_zero);
    assign ieee_lt = !any_nan && a_lt_b && !both_zero;

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    always_comb begin
        res_d   = '0;
        nv      = 1'b0;
        cmp_bit = 1'b0;
        case (unit_op_i)
            SGNJ: begin
                case (sub_op_i)
                    SUB_SGNJ:  res_d = {operand_b_i[31], operand_a_i[30:0]};
                    SUB_SGNJN: res_d = {~operand_b_i[31], operand_a_i[30:0]};
                    SUB_SGNJX: res_d = {operand_a_i[31] ^ operand_b_i[31], operand_a_i[30:0]};
                    default:   res_d = operand_a_i;                // Passthrough for moves
                endcase
            end
            MINMAX: begin
                nv = any_snan;
                if (a_nan && b_nan)      res_d = CANON_NAN;
                else if (a_nan)          res_d = operand_b_i;      // NaN loses
                else if (b_nan)          res_d = operand_a_i;
                else if (sub_op_i == SUB_MAX) res_d = a_lt_b ? operand_b_i : operand_a_i;
                else                     res_d = a_lt_b ? operand_a_i : operand_b_i;
            end
            CMP: begin
                case (sub_op_i)
                    SUB_LE: begin
                        cmp_bit = ieee_lt || ieee_eq;
                        nv      = any_nan;                         // Signaling compare
                    end
                    SUB_LT: begin
                        cmp_bit = ieee_lt;
                        nv      = any_nan;
                    end
                    SUB_EQ: begin
                        cmp_bit = ieee_eq;
                        nv      = any_snan;                        // Quiet compare
                    end
                    default: ;
                endcase
                res_d = operand_t'(cmp_bit ^ op_mod_i);
            end
            default: res_d = operand_t'(class_a);                  // CLASSIFY
        endcase
    end

    // ----------------------------------------
    // Stage registers
    // ----------------------------------------
    logic     valid_q [NUM_STAGES];
    operand_t res_q   [NUM_STAGES];
    status_t  stat_q  [NUM_STAGES];
    tag_t     tag_q   [NUM_STAGES];
    logic     advance;

    assign advance    = out_ready_i || !valid_q[NUM_STAGES-1];  // Bubble or drain
    assign in_ready_o = advance;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            for (int i = 0; i < NUM_STAGES; i++) valid_q[i] <= 1'b0;
        end else if (advance) begin
            valid_q[0] <= in_valid_i;
            for (int i = 1; i < NUM_STAGES; i++) valid_q[i] <= valid_q[i-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            res_q[0]  <= res_d;
            stat_q[0] <= {nv, 4'b0000};  // Only NV can be raised here
            tag_q[0]  <= tag_i;
            for (int i = 1; i < NUM_STAGES; i++) begin
                res_q[i]  <= res_q[i-1];
                stat_q[i] <= stat_q[i-1];
                tag_q[i]  <= tag_q[i-1];
            end
        end
    end

    assign out_valid_o = valid_q[NUM_STAGES-1];
    assign result_o    = res_q[NUM_STAGES-1];
    assign status_o    = stat_q[NUM_STAGES-1];
    assign tag_o       = tag_q[NUM_STAGES-1];

    // Sink sees a frozen result while it stalls
    a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o));

endmodule

`default_nettype wire

//--- fpu_hold_buffer.sv
// Keeps one refused command with its operands and tag, and selects held or live copy for issue
`timescale 1ns/1ps
`default_nettype none

module fpu_hold_buffer (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 hold_i,      // Capture the live command
    input  logic                 use_hold_i,  // Present the captured one
    input  fpu_op_pkg::unit_op_e unit_op_i,
    input  logic                 op_mod_i,
    input  fpu_op_pkg::sub_op_t  sub_op_i,
    input  fpu_cfg_pkg::operand_t operand_a_i,
    input  fpu_cfg_pkg::operand_t operand_b_i,
    input  fpu_cfg_pkg::tag_t    tag_i,
    output fpu_op_pkg::unit_op_e unit_op_o,
    output logic                 op_mod_o,
    output fpu_op_pkg::sub_op_t  sub_op_o,
    output fpu_cfg_pkg::operand_t operand_a_o,
    output fpu_cfg_pkg::operand_t operand_b_o,
    output fpu_cfg_pkg::tag_t    tag_o
);
    import fpu_cfg_pkg::*;
    import fpu_op_pkg::*;

    unit_op_e unit_op_q;
    logic     op_mod_q;
    sub_op_t  sub_op_q;
    operand_t operand_a_q, operand_b_q;
    tag_t     tag_q;

    // Command fields
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            unit_op_q <= SGNJ;
            op_mod_q  <= 1'b0;
            sub_op_q  <= SUB_SGNJ;
        end else if (hold_i) begin
            unit_op_q <= unit_op_i;
            op_mod_q  <= op_mod_i;
            sub_op_q  <= sub_op_i;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (hold_i) begin
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_i;
            tag_q       <= tag_i;
        end
    end

    // Bypass select
    assign unit_op_o   = use_hold_i ? unit_op_q   : unit_op_i;
    assign op_mod_o    = use_hold_i ? op_mod_q    : op_mod_i;
    assign sub_op_o    = use_hold_i ? sub_op_q    : sub_op_i;
    assign operand_a_o = use_hold_i ? operand_a_q : operand_a_i;
    assign operand_b_o = use_hold_i ? operand_b_q : operand_b_i;
    assign tag_o       = use_hold_i ? tag_q       : tag_i;

endmodule

`default_nettype wire

//--- fpu_issue_fsm.sv
// READY/STALL machine that turns the upstream valid/ready into a take-over of refused commands
`timescale 1ns/1ps
`default_nettype none

module fpu_issue_fsm (
    input  logic clk_i,
    input  logic rst_i,
    input  logic flush_i,
    input  logic fpu_valid_i,   // Issuer has a command
    input  logic unit_ready_i,  // Pipeline advances this cycle
    output logic fpu_ready_o,
    output logic unit_valid_o,
    output logic hold_o,        // Load the hold buffer
    output logic use_hold_o     // Feed the pipeline from the hold buffer
);

    typedef enum logic {READY, STALL} state_e;

    state_e state_q, state_d;

    // ----------------------------------------
    // Next state and outputs
    // ----------------------------------------
    always_comb begin
        fpu_ready_o  = 1'b0;
        unit_valid_o = 1'b0;
        hold_o       = 1'b0;
        use_hold_o   = 1'b0;
        state_d      = state_q;

        case (state_q)
            READY: begin
                fpu_ready_o  = 1'b1;         // Looks ready to the issuer
                unit_valid_o = fpu_valid_i;  // Live command straight through
                if (fpu_valid_i && !unit_ready_i) begin
                    fpu_ready_o = 1'b0;      // Refused, keep it ourselves
                    hold_o      = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                unit_valid_o = 1'b1;         // Held command is pending
                use_hold_o   = 1'b1;
                if (unit_ready_i) begin
                    fpu_ready_o = 1'b1;      // Token back to the issuer
                    state_d     = READY;
                end
            end
            default: state_d = READY;
        endcase

        // Flush wins over everything
        if (flush_i) begin
            state_d = READY;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // A load is always followed by a STALL cycle that does not reload the buffer
    a_hold_once: assert property (@(posedge clk_i) disable iff (rst_i)
        hold_o && !flush_i |=> state_q == STALL && !hold_o);

endmodule

`default_nettype wire

//--- fpu_op_decode.sv
// Turns the issue operator and its rm field into a unit operation, op modifier and sub-op
`timescale 1ns/1ps
`default_nettype none

module fpu_op_decode (
    input  fpu_op_pkg::fu_op_e   fu_op_i,
    input  fpu_op_pkg::sub_op_t  rm_i,
    output fpu_op_pkg::unit_op_e unit_op_o,
    output logic                 op_mod_o,
    output fpu_op_pkg::sub_op_t  sub_op_o
);
    import fpu_op_pkg::*;

    always_comb begin
        // Plain sign injection unless the operator says otherwise
        unit_op_o = SGNJ;
        op_mod_o  = 1'b0;
        sub_op_o  = SUB_SGNJ;

        case (fu_op_i)
            FSGNJ: begin
                unit_op_o = SGNJ;
                sub_op_o  = {1'b0, rm_i[1:0]};  // Top rm bit is ignored
            end
            FMIN_MAX: begin
                unit_op_o = MINMAX;
                sub_op_o  = {1'b0, rm_i[1:0]};  // 0 min, 1 max
            end
            FCMP: begin
                unit_op_o = CMP;
                sub_op_o  = {1'b0, rm_i[1:0]};  // LE, LT, EQ
            end
            FCLASS: begin
                unit_op_o = CLASSIFY;
                sub_op_o  = {1'b0, rm_i[1:0]};  // Don't care for classify
            end
            // Moves need no recoding, so they run as passthrough
            FMV_F2X: begin
                unit_op_o = SGNJ;
                sub_op_o  = SUB_PASS;
                op_mod_o  = 1'b1;                // No NaN boxing toward integer side
            end
            FMV_X2F: begin
                unit_op_o = SGNJ;
                sub_op_o  = SUB_PASS;
            end
            default: ;                           // Keep defaults
        endcase
    end

endmodule

`default_nettype wire

//--- fpu_op_pkg.sv
// Operator, unit-op and sub-op encodings used by the decoder and the execution pipeline
`default_nettype none

package fpu_op_pkg;

    // ----------------------------------------
    // Issue side operators
    // ----------------------------------------
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,  // Sign injection, variant in rm
        FMIN_MAX = 3'd1,  // Min or max, selected by rm
        FCMP     = 3'd2,  // FLE / FLT / FEQ in rm
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,  // FP register to integer register
        FMV_X2F  = 3'd5   // Integer register to FP register
    } fu_op_e;

    // ----------------------------------------
    // Unit operations
    // ----------------------------------------
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } unit_op_e;

    // Sub-op travels in the rounding mode slot
    typedef logic [2:0] sub_op_t;

    localparam sub_op_t SUB_SGNJ  = 3'd0;  // Sign of b
    localparam sub_op_t SUB_SGNJN = 3'd1;  // Inverted sign of b
    localparam sub_op_t SUB_SGNJX = 3'd2;  // Sign a xor sign b
    localparam sub_op_t SUB_PASS  = 3'd3;  // Operand a unchanged, used by moves
    localparam sub_op_t SUB_MAX   = 3'd1;  // Min is the default
    localparam sub_op_t SUB_LE    = 3'd0;
    localparam sub_op_t SUB_LT    = 3'd1;
    localparam sub_op_t SUB_EQ    = 3'd2;

    // Result of min/max when both inputs are NaN
    localparam fpu_cfg_pkg::operand_t CANON_NAN = 32'h7fc0_0000;

endpackage

`default_nettype wire

//--- fpu_cfg_pkg.sv
// Data widths and vector types shared by the FP32 datapath, imported by every RTL block
`default_nettype none

package fpu_cfg_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned FLEN          = 32;  // Single precision only
    localparam int unsigned TRANS_ID_BITS = 3;   // Scoreboard tag

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [FLEN-1:0]          operand_t;  // Raw FP32 bit pattern
    typedef logic [TRANS_ID_BITS-1:0] tag_t;      // Transaction ID
    typedef logic [4:0]               status_t;   // {NV, DZ, OF, UF, NX}
    typedef logic [9:0]               class_t;    // FCLASS one-hot

endpackage

`default_nettype wire
